// File: run.sh
#!/usr/bin/env bash
# Build and run the FIR testbench with Verilator
set -e

cd "$(dirname "$0")"

BUILD_DIR=obj_dir
LOG_FILE=sim.log

rm -rf "$BUILD_DIR" "$LOG_FILE"

verilator --binary --timing --assert -j 0 \
    --top-module fir_tb \
    -Mdir "$BUILD_DIR" \
    -f sim.f

# A failing run still leaves its log for the search below
"./$BUILD_DIR/Vfir_tb" > "$LOG_FILE" 2>&1 || true
cat "$LOG_FILE"

if grep -q "^Result: PASSED$" "$LOG_FILE"; then
    echo "Simulation run passed"
    exit 0
else
    echo "Simulation run failed, see $LOG_FILE"
    exit 1
fi

// File: sim.f
src/fir_pkg.sv
src/shift_reg.sv
src/fir_coef_regs.sv
src/fir_filter.sv
src/fir_output_scaler.sv
src/fir_top.sv
tb/fir_tb_props.sv
tb/fir_tb.sv

// File: src/fir_coef_regs.sv
/* FIR configuration registers
   Holds the coefficient bank and output shift, and issues flush pulses */
module fir_coef_regs (
    input  logic                               clk_i,
    input  logic                               rstn_i,
    input  logic                               cfg_we_i,
    input  fir_pkg::cfg_req_t                  cfg_i,
    output fir_pkg::coef_bank_t                coef_bank_o,
    output logic [fir_pkg::SHIFT_WIDTH-1:0]    shift_o,
    output logic                               flush_o
);

    fir_pkg::coef_bank_t                coef_q;
    logic [fir_pkg::SHIFT_WIDTH-1:0]    shift_q;
    logic                               flush_q;

    // ************************************************************************
    // Request decode
    // ************************************************************************

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            coef_q  <= '0;
            shift_q <= '0;
            flush_q <= 1'b0;
        end else begin
            flush_q <= 1'b0;  // Single cycle pulse
            if (cfg_we_i) begin
                case (cfg_i.op)
                    fir_pkg::CFG_WRITE_COEF: begin
                        coef_q[cfg_i.addr] <= cfg_i.data;
                    end
                    fir_pkg::CFG_WRITE_SHIFT: begin
                        shift_q <= cfg_i.data[fir_pkg::SHIFT_WIDTH-1:0];
                    end
                    fir_pkg::CFG_FLUSH: begin
                        flush_q <= 1'b1;
                    end
                    default: begin
                        // CFG_NOP leaves state untouched
                    end
                endcase
            end
        end
    end

    // ************************************************************************
    // Outputs
    // ************************************************************************

    assign coef_bank_o = coef_q;
    assign shift_o     = shift_q;
    assign flush_o     = flush_q;

endmodule

// File: src/fir_filter.sv
/* Pipelined FIR core
   Sample delay line, registered tap products and a pairwise adder tree */
module fir_filter (
    input  logic                clk_i,
    input  logic                rstn_i,
    input  logic                en_i,
    input  logic                valid_i,
    input  logic                flush_i,
    input  fir_pkg::sample_t    sample_i,
    input  fir_pkg::coef_bank_t coef_bank_i,
    output fir_pkg::acc_t       sum_o
);

    fir_pkg::sample_t                        delay_q [fir_pkg::TAP_NUM];
    logic signed [fir_pkg::PROD_WIDTH-1:0]   mult_q  [fir_pkg::TAP_NUM];
    fir_pkg::acc_t                           acc_q   [fir_pkg::TAP_NUM-1];

    logic                                    accept;

    assign accept = en_i & valid_i;  // Line moves only on accepted samples

    // ************************************************************************
    // Delay line and tap products
    // ************************************************************************

    for (genvar k = 0; k < fir_pkg::TAP_NUM; k++) begin : g_tap
        if (k == 0) begin : g_first
            always_ff @(posedge clk_i) begin
                if (!rstn_i || flush_i) begin
                    delay_q[k] <= '0;
                end else if (accept) begin
                    delay_q[k] <= sample_i;
                end
            end
        end else begin : g_others
            always_ff @(posedge clk_i) begin
                if (!rstn_i || flush_i) begin
                    delay_q[k] <= '0;
                end else if (accept) begin
                    delay_q[k] <= delay_q[k-1];
                end
            end
        end

        always_ff @(posedge clk_i) begin
            if (en_i) begin
                mult_q[k] <= delay_q[k] * $signed(coef_bank_i[k]);
            end
        end
    end

    // ************************************************************************
    // Adder tree
    // Slots below TAP_NUM/2 add product pairs, the rest add earlier sums.
    // The last slot holds the full sum.
    // ************************************************************************

    for (genvar i = 0; i < fir_pkg::TAP_NUM - 1; i++) begin : g_acc
        if (i < fir_pkg::TAP_NUM / 2) begin : g_first_level
            always_ff @(posedge clk_i) begin
                if (en_i) begin
                    acc_q[i] <= fir_pkg::acc_t'(mult_q[2*i])
                              + fir_pkg::acc_t'(mult_q[2*i+1]);
                end
            end
        end else begin : g_upper_level
            always_ff @(posedge clk_i) begin
                if (en_i) begin
                    acc_q[i] <= acc_q[2*(i-fir_pkg::TAP_NUM/2)]
                              + acc_q[2*(i-fir_pkg::TAP_NUM/2)+1];
                end
            end
        end
    end

    assign sum_o = acc_q[fir_pkg::TAP_NUM-2];

endmodule

// File: src/fir_output_scaler.sv
/* FIR output scaler
   Rounds, shifts right arithmetically and saturates the sum to sample width */
module fir_output_scaler (
    input  logic                            clk_i,
    input  logic                            en_i,
    input  fir_pkg::acc_t                   sum_i,
    input  logic [fir_pkg::SHIFT_WIDTH-1:0] shift_i,
    output fir_pkg::sample_t                sample_o
);

    // One guard bit so the rounding add cannot wrap
    logic signed [fir_pkg::ACC_WIDTH:0] round_c;
    logic signed [fir_pkg::ACC_WIDTH:0] rounded;
    logic signed [fir_pkg::ACC_WIDTH:0] shifted;
    logic                               in_range;
    fir_pkg::sample_t                   sat;

    // ************************************************************************
    // Round and shift
    // ************************************************************************

    always_comb begin
        if (shift_i == '0) begin
            round_c = '0;
        end else begin
            round_c = {{(fir_pkg::ACC_WIDTH){1'b0}}, 1'b1} << (shift_i - 1'b1);  // Half LSB
        end
        rounded = {sum_i[fir_pkg::ACC_WIDTH-1], sum_i} + round_c;
        shifted = rounded >>> shift_i;
    end

    // ************************************************************************
    // Saturate
    // ************************************************************************

    // Fits when every bit above the sample sign matches it
    assign in_range = (&shifted[fir_pkg::ACC_WIDTH:fir_pkg::DATA_WIDTH-1])
                    | ~(|shifted[fir_pkg::ACC_WIDTH:fir_pkg::DATA_WIDTH-1]);

    always_comb begin
        if (in_range) begin
            sat = shifted[fir_pkg::DATA_WIDTH-1:0];
        end else if (shifted[fir_pkg::ACC_WIDTH]) begin
            sat = {1'b1, {(fir_pkg::DATA_WIDTH-1){1'b0}}};  // Most negative
        end else begin
            sat = {1'b0, {(fir_pkg::DATA_WIDTH-1){1'b1}}};  // Most positive
        end
    end

    always_ff @(posedge clk_i) begin
        if (en_i) begin
            sample_o <= sat;
        end
    end

endmodule

// File: src/fir_pkg.sv
/* FIR filter package
   Widths, tap count, pipeline latency, configuration opcodes and shared types */
package fir_pkg;

    // ************************************************************************
    // Widths and sizes
    // ************************************************************************

    localparam int DATA_WIDTH  = 16;  // Sample width
    localparam int COEF_WIDTH  = 18;  // Coefficient width
    localparam int TAP_NUM     = 8;   // Power of two for an even adder tree

    localparam int PROD_WIDTH  = DATA_WIDTH + COEF_WIDTH;
    localparam int ACC_WIDTH   = PROD_WIDTH + $clog2(TAP_NUM);  // Growth over tree levels

    localparam int SHIFT_WIDTH = 6;
    localparam int ADDR_WIDTH  = $clog2(TAP_NUM);

    // Delay line, multiply, tree levels and scaler
    localparam int LATENCY     = 1 + 1 + $clog2(TAP_NUM) + 1;

    // ************************************************************************
    // Data types
    // ************************************************************************

    typedef logic signed [DATA_WIDTH-1:0] sample_t;
    typedef logic signed [COEF_WIDTH-1:0] coef_t;
    typedef logic signed [ACC_WIDTH-1:0]  acc_t;

    typedef coef_t [TAP_NUM-1:0] coef_bank_t;  // Tap 0 in the low slot

    // ************************************************************************
    // Configuration interface
    // ************************************************************************

    typedef enum logic [1:0] {
        CFG_NOP         = 2'b00,
        CFG_WRITE_COEF  = 2'b01,
        CFG_WRITE_SHIFT = 2'b10,
        CFG_FLUSH       = 2'b11
    } cfg_op_e;

    typedef struct packed {
        cfg_op_e                op;
        logic [ADDR_WIDTH-1:0]  addr;  // Tap index for coefficient writes
        coef_t                  data;  // Low bits carry the shift amount
    } cfg_req_t;

endpackage

// File: src/fir_top.sv
/* FIR subsystem top level
   Joins configuration, filter core, output scaler and validity delay */
module fir_top (
    input  logic              clk_i,
    input  logic              rstn_i,
    input  logic              en_i,
    input  logic              valid_i,
    input  logic              cfg_we_i,
    input  fir_pkg::sample_t  sample_i,
    input  fir_pkg::cfg_req_t cfg_i,
    output fir_pkg::sample_t  sample_o,
    output logic              valid_o
);

    fir_pkg::coef_bank_t             coef_bank;
    logic [fir_pkg::SHIFT_WIDTH-1:0] shift;
    logic                            flush;
    fir_pkg::acc_t                   sum;

    fir_coef_regs u_fir_coef_regs (
        .clk_i      (clk_i),
        .rstn_i     (rstn_i),
        .cfg_we_i   (cfg_we_i),
        .cfg_i      (cfg_i),
        .coef_bank_o(coef_bank),
        .shift_o    (shift),
        .flush_o    (flush)
    );

    fir_filter u_fir_filter (
        .clk_i      (clk_i),
        .rstn_i     (rstn_i),
        .en_i       (en_i),
        .valid_i    (valid_i),
        .flush_i    (flush),
        .sample_i   (sample_i),
        .coef_bank_i(coef_bank),
        .sum_o      (sum)
    );

    fir_output_scaler u_fir_output_scaler (
        .clk_i   (clk_i),
        .en_i    (en_i),
        .sum_i   (sum),
        .shift_i (shift),
        .sample_o(sample_o)
    );

    // Validity follows the data path stage for stage
    shift_reg #(
        .WIDTH(1),
        .DELAY(fir_pkg::LATENCY)
    ) u_valid_delay (
        .clk_i (clk_i),
        .rstn_i(rstn_i),
        .en_i  (en_i),
        .data_i(valid_i),
        .data_o(valid_o)
    );

endmodule

// File: src/shift_reg.sv
/* Enabled delay line with reset
   The last stage reads as zero after an edge with the enable low */
module shift_reg #(
    parameter int WIDTH = 1,
    parameter int DELAY = 1
) (
    input  logic             clk_i,
    input  logic             rstn_i,
    input  logic             en_i,
    input  logic [WIDTH-1:0] data_i,
    output logic [WIDTH-1:0] data_o
);

    logic [WIDTH-1:0] chain [DELAY+1];  // chain[0] is the input tap

    assign chain[0] = data_i;

    for (genvar i = 0; i < DELAY; i++) begin : g_stage
        always_ff @(posedge clk_i) begin
            if (!rstn_i) begin
                chain[i+1] <= '0;
            end else if (en_i) begin
                chain[i+1] <= chain[i];
            end else if (i == DELAY - 1) begin
                chain[i+1] <= '0;  // Output only after an enabled edge
            end
        end
    end

    assign data_o = chain[DELAY];

endmodule

// File: tb/fir_tb.sv
/* FIR subsystem testbench
   Table driven stimulus checked against a reference model of the output rule */
module fir_tb;

    localparam logic [31:0] LFSR_SEED  = 32'hc790;
    localparam logic [31:0] LFSR_TAPS  = 32'h8020_0003;  // x^32 + x^22 + x^2 + x + 1
    localparam int          DRAIN_ROWS = 8;              // Enough to empty the pipeline

    typedef struct packed {
        logic              is_cfg;
        fir_pkg::cfg_req_t cfg;
        fir_pkg::sample_t  sample;
        logic              valid;
        logic              en;
        fir_pkg::sample_t  expected;  // Filled by the reference model
    } row_t;

    logic              clk;
    logic              rstn;
    logic              en;
    logic              valid_in;
    logic              cfg_we;
    fir_pkg::sample_t  sample_in;
    fir_pkg::cfg_req_t cfg_req;
    fir_pkg::sample_t  sample_out;
    logic              valid_out;

    row_t              table_q [$];
    fir_pkg::sample_t  expected_q [$];
    logic [31:0]       lfsr_state;
    int                cycle_cnt;
    int                cycle_limit;
    logic              last_en;

    fir_top u_fir_top (
        .clk_i   (clk),
        .rstn_i  (rstn),
        .en_i    (en),
        .valid_i (valid_in),
        .cfg_we_i(cfg_we),
        .sample_i(sample_in),
        .cfg_i   (cfg_req),
        .sample_o(sample_out),
        .valid_o (valid_out)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_limit != 0 && cycle_cnt >= cycle_limit) begin
            stop_with_error($sformatf("Timeout: no end of run after %0d cycles", cycle_limit));
        end
    end

    // ************************************************************************
    // Random numbers and failure reporting
    // ************************************************************************

    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ LFSR_TAPS;
        end
        return state >> 1;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] value;
        value = '0;
        for (int b = 0; b < n; b++) begin
            value = {value[30:0], lfsr_state[0]};  // One step per bit
            lfsr_state = lfsr_next(lfsr_state);
        end
        return value;
    endfunction

    function automatic fir_pkg::coef_t small_coef();
        logic [31:0] bits;
        bits = rand_bits(10);
        return fir_pkg::coef_t'($signed(bits[9:0]));
    endfunction

    task automatic stop_with_error(input string line);
        $display("%s", line);
        $display("Result: FAILED");
        $fatal(1, "Simulation stopped after an error");
    endtask

    task automatic check_sample(input fir_pkg::sample_t actual, input fir_pkg::sample_t expected,
                                input string what);
        if (actual !== expected) begin
            stop_with_error($sformatf("Mismatch at time %0t: %s is %0d, expected %0d",
                                      $time, what, actual, expected));
        end
    endtask

    task automatic check_valid(input logic actual, input logic expected, input string what);
        if (actual !== expected) begin
            stop_with_error($sformatf("Mismatch at time %0t: %s is %b, expected %b",
                                      $time, what, actual, expected));
        end
    endtask

    // ************************************************************************
    // Stimulus table
    // ************************************************************************

    task automatic add_cfg(input fir_pkg::cfg_op_e op, input int addr, input fir_pkg::coef_t data);
        row_t row;
        row = '0;
        row.is_cfg = 1'b1;
        row.cfg.op = op;
        row.cfg.addr = addr[fir_pkg::ADDR_WIDTH-1:0];
        row.cfg.data = data;
        row.en = 1'b1;
        table_q.push_back(row);
    endtask

    task automatic add_sample(input fir_pkg::sample_t sample, input logic valid, input logic en_lvl);
        row_t row;
        row = '0;
        row.sample = sample;
        row.valid = valid;
        row.en = en_lvl;
        table_q.push_back(row);
    endtask

    task automatic add_idle(input int n);
        for (int i = 0; i < n; i++) begin
            add_sample('0, 1'b0, 1'b1);
        end
    endtask

    task automatic add_random_samples(input int n, input logic with_holds);
        fir_pkg::sample_t sample;
        logic             valid;
        int               stretch;
        for (int i = 0; i < n; i++) begin
            if (with_holds && rand_bits(3) == 32'd0) begin
                stretch = int'(rand_bits(2)) + 1;
                for (int h = 0; h < stretch; h++) begin
                    sample = fir_pkg::sample_t'(rand_bits(16));
                    valid = rand_bits(1) != 32'd0;
                    add_sample(sample, valid, 1'b0);  // Held, never accepted
                end
            end
            sample = fir_pkg::sample_t'(rand_bits(16));
            valid = rand_bits(2) != 32'd0;
            add_sample(sample, valid, 1'b1);
        end
    endtask

    task automatic build_table();
        add_idle(4);
        add_random_samples(4, 1'b0);  // All coefficients still zero
        add_idle(DRAIN_ROWS);

        // Impulse response
        add_cfg(fir_pkg::CFG_FLUSH, 0, '0);
        add_idle(2);
        for (int k = 0; k < fir_pkg::TAP_NUM; k++) begin
            add_cfg(fir_pkg::CFG_WRITE_COEF, k, fir_pkg::coef_t'(k + 1));
        end
        add_cfg(fir_pkg::CFG_WRITE_SHIFT, 0, '0);
        add_sample(fir_pkg::sample_t'(1), 1'b1, 1'b1);
        for (int k = 1; k < fir_pkg::TAP_NUM; k++) begin
            add_sample('0, 1'b1, 1'b1);
        end
        add_idle(DRAIN_ROWS);

        // Random data with rounding
        for (int k = 0; k < fir_pkg::TAP_NUM; k++) begin
            add_cfg(fir_pkg::CFG_WRITE_COEF, k, small_coef());
        end
        add_cfg(fir_pkg::CFG_WRITE_SHIFT, 0, fir_pkg::coef_t'(4));
        add_random_samples(40, 1'b0);
        add_idle(DRAIN_ROWS);

        // Saturation at both ends
        for (int k = 0; k < fir_pkg::TAP_NUM; k++) begin
            add_cfg(fir_pkg::CFG_WRITE_COEF, k, fir_pkg::coef_t'(131071));
        end
        add_cfg(fir_pkg::CFG_WRITE_SHIFT, 0, '0);
        for (int i = 0; i < 8; i++) begin
            add_sample(fir_pkg::sample_t'(32767), 1'b1, 1'b1);
        end
        for (int i = 0; i < 8; i++) begin
            add_sample(fir_pkg::sample_t'(-32768), 1'b1, 1'b1);
        end
        add_idle(DRAIN_ROWS);

        // Enable held low in stretches
        for (int k = 0; k < fir_pkg::TAP_NUM; k++) begin
            add_cfg(fir_pkg::CFG_WRITE_COEF, k, small_coef());
        end
        add_cfg(fir_pkg::CFG_WRITE_SHIFT, 0, fir_pkg::coef_t'(3));
        add_random_samples(40, 1'b1);
        add_idle(DRAIN_ROWS);

        // Flush then a single accepted sample
        add_cfg(fir_pkg::CFG_FLUSH, 0, '0);
        add_idle(2);
        add_sample(fir_pkg::sample_t'(rand_bits(16)), 1'b1, 1'b1);
        add_idle(DRAIN_ROWS);
    endtask

    // Sum of taps, round half up, arithmetic shift, clamp
    task automatic fill_expected();
        longint coef [fir_pkg::TAP_NUM];
        longint hist [fir_pkg::TAP_NUM];
        longint acc;
        int     shift;
        row_t   row;
        for (int k = 0; k < fir_pkg::TAP_NUM; k++) begin
            coef[k] = 0;
            hist[k] = 0;
        end
        shift = 0;
        for (int i = 0; i < table_q.size(); i++) begin
            row = table_q[i];
            if (row.is_cfg) begin
                case (row.cfg.op)
                    fir_pkg::CFG_WRITE_COEF:  coef[row.cfg.addr] = $signed(row.cfg.data);
                    fir_pkg::CFG_WRITE_SHIFT: shift = int'(row.cfg.data[fir_pkg::SHIFT_WIDTH-1:0]);
                    fir_pkg::CFG_FLUSH: begin
                        for (int k = 0; k < fir_pkg::TAP_NUM; k++) begin
                            hist[k] = 0;
                        end
                    end
                    default: begin
                    end
                endcase
            end else if (row.valid && row.en) begin
                for (int k = fir_pkg::TAP_NUM - 1; k > 0; k--) begin
                    hist[k] = hist[k-1];
                end
                hist[0] = $signed(row.sample);
                acc = 0;
                for (int k = 0; k < fir_pkg::TAP_NUM; k++) begin
                    acc = acc + coef[k] * hist[k];
                end
                if (shift != 0) begin
                    acc = acc + (longint'(1) << (shift - 1));
                end
                acc = acc >>> shift;
                if (acc > 32767) begin
                    acc = 32767;
                end else if (acc < -32768) begin
                    acc = -32768;
                end
                row.expected = fir_pkg::sample_t'(acc);
                table_q[i] = row;
            end
        end
    endtask

    // ************************************************************************
    // Apply loop
    // ************************************************************************

    task automatic apply_row(input row_t row);
        cfg_we = row.is_cfg;
        cfg_req = row.cfg;
        sample_in = row.sample;
        valid_in = row.valid;
        en = row.en;
        if (!row.is_cfg && row.valid && row.en) begin
            expected_q.push_back(row.expected);  // Acceptance order
        end
    endtask

    task automatic check_outputs(input logic prev_en);
        if (!prev_en) begin
            check_valid(valid_out, 1'b0, "valid_o after an edge with en_i low");
        end
        if (valid_out === 1'b1) begin
            if (expected_q.size() == 0) begin
                stop_with_error("valid_o went high with no result outstanding");
            end else begin
                check_sample(sample_out, expected_q.pop_front(), "sample_o");
            end
        end else if (valid_out !== 1'b0) begin
            stop_with_error("valid_o is neither high nor low");
        end
    endtask

    initial begin
        lfsr_state = LFSR_SEED;
        cycle_cnt = 0;
        cycle_limit = 0;
        rstn = 1'b0;
        en = 1'b0;
        valid_in = 1'b0;
        cfg_we = 1'b0;
        sample_in = '0;
        cfg_req = '0;
        build_table();
        fill_expected();
        cycle_limit = 2 * table_q.size() + 100;

        repeat (5) @(posedge clk);
        #1;
        rstn = 1'b1;
        check_valid(valid_out, 1'b0, "valid_o after reset");

        foreach (table_q[i]) begin
            apply_row(table_q[i]);
            last_en = table_q[i].en;
            @(posedge clk);
            #1;
            check_outputs(last_en);
        end

        if (expected_q.size() != 0) begin
            stop_with_error($sformatf("%0d expected results never appeared on the output",
                                      expected_q.size()));
        end else begin
            $display("Result: PASSED");
            $finish;
        end
    end

endmodule

// File: tb/fir_tb_props.sv
/* FIR top level assertions
   Output validity around reset and enable, and known configuration opcodes */
module fir_tb_props (
    input logic              clk_i,
    input logic              rstn_i,
    input logic              en_i,
    input logic              cfg_we_i,
    input fir_pkg::cfg_req_t cfg_i,
    input logic              out_valid_i
);

    // ************************************************************************
    // Validity
    // ************************************************************************

    a_reset_clears_valid : assert property (
        @(posedge clk_i) !rstn_i |=> !out_valid_i
    ) else $error("valid_o high during reset or in the cycle after it");

    a_hold_clears_valid : assert property (
        @(posedge clk_i) !en_i |=> !out_valid_i
    ) else $error("valid_o high in the cycle after an edge with en_i low");

    // ************************************************************************
    // Configuration
    // ************************************************************************

    a_cfg_op_known : assert property (
        @(posedge clk_i) disable iff (!rstn_i) cfg_we_i |-> !$isunknown(cfg_i.op)
    ) else $error("configuration strobe with an unknown opcode");

endmodule

bind fir_top fir_tb_props u_fir_tb_props (
    .clk_i      (clk_i),
    .rstn_i     (rstn_i),
    .en_i       (en_i),
    .cfg_we_i   (cfg_we_i),
    .cfg_i      (cfg_i),
    .out_valid_i(valid_o)
);
